// ==== rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // integer physical register file size
    localparam int PHYREG_NUM = 64;

    localparam int PRIDX_W = $clog2(PHYREG_NUM);

    typedef logic [PRIDX_W-1:0] pr_idx_t;

    // register 0 never enters the free list
    localparam int FREE_DEPTH = PHYREG_NUM - 1;

    // default lane counts, overridden from the top level
    localparam int DEF_RENAME_WIDTH = 4;
    localparam int DEF_COMMIT_WIDTH = 4;

    // population count of a lane mask
    // masks are zero extended, so up to 32 lanes are supported
    function automatic int unsigned count_ones(input logic [31:0] mask);
        int unsigned ones;
        ones = 0;
        for (int b = 0; b < 32; b++) begin
            ones += 32'(mask[b]);
        end
        return ones;
    endfunction

endpackage

`default_nettype wire

// ==== fifo_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_port_if
    import rename_pkg::*;
#(
    parameter int RENAME_WIDTH = DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
) ();

    // write side, dense from lane 0
    logic [COMMIT_WIDTH-1:0] wen;
    pr_idx_t                 wdata [COMMIT_WIDTH];

    // bit k set when at least k+1 entries are stored
    logic [RENAME_WIDTH-1:0] can_read;

    // read side, dense from lane 0, rdata shows the head onward
    logic [RENAME_WIDTH-1:0] ren;
    pr_idx_t                 rdata [RENAME_WIDTH];

    modport producer (
        output wen,
        output wdata,
        output ren,
        input  can_read,
        input  rdata
    );

    modport storage (
        input  wen,
        input  wdata,
        input  ren,
        output can_read,
        output rdata
    );

endinterface

`default_nettype wire

// ==== reorder.sv ====
`timescale 1ns/1ps
`default_nettype none

// packs the valid lanes of a sparse group into the low lanes
// e.g. vld 1010 with data d c b a gives vld 0011 with data x x d b
module reorder
    import rename_pkg::*;
#(
    parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
) (
    input  logic [COMMIT_WIDTH-1:0] i_data_vld,
    input  pr_idx_t                 i_datas [COMMIT_WIDTH],
    output logic [COMMIT_WIDTH-1:0] o_data_vld,
    output pr_idx_t                 o_datas [COMMIT_WIDTH]
);

    // number of valid lanes strictly below each lane
    int unsigned below [COMMIT_WIDTH];
    int unsigned vld_cnt;

    always_comb begin
        for (int unsigned i = 0; i < COMMIT_WIDTH; i++) begin
            below[i] = count_ones(32'(i_data_vld) & ((32'd1 << i) - 32'd1));
        end
    end

    assign vld_cnt = count_ones(32'(i_data_vld));

    // output lane j takes the valid input whose rank is j
    always_comb begin
        for (int unsigned j = 0; j < COMMIT_WIDTH; j++) begin
            o_data_vld[j] = (j < vld_cnt);
            o_datas[j]    = '0;
            for (int unsigned i = 0; i < COMMIT_WIDTH; i++) begin
                if (i_data_vld[i] && (below[i] == j)) begin
                    o_datas[j] = i_datas[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

// inverse of reorder, spreads a dense group over the set request lanes
// e.g. req 1001 with dense data x x b a gives b x x a
module redirect
    import rename_pkg::*;
#(
    parameter int RENAME_WIDTH = DEF_RENAME_WIDTH
) (
    input  logic [RENAME_WIDTH-1:0] i_req_vld,
    input  pr_idx_t                 i_dense_datas [RENAME_WIDTH],
    output pr_idx_t                 o_sparse_datas [RENAME_WIDTH]
);

    // rank of each lane among the requesting lanes
    int unsigned below [RENAME_WIDTH];

    always_comb begin
        for (int unsigned i = 0; i < RENAME_WIDTH; i++) begin
            below[i] = count_ones(32'(i_req_vld) & ((32'd1 << i) - 32'd1));
        end
    end

    // lanes without a request still get an entry, callers ignore it
    always_comb begin
        for (int unsigned i = 0; i < RENAME_WIDTH; i++) begin
            o_sparse_datas[i] = i_dense_datas[0];
            for (int unsigned k = 1; k < RENAME_WIDTH; k++) begin
                if (below[i] == k) begin
                    o_sparse_datas[i] = i_dense_datas[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== multiport_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// circular FIFO with COMMIT_WIDTH write lanes and RENAME_WIDTH read lanes
// comes out of reset full, holding indices 1 .. FREE_DEPTH
module multiport_fifo
    import rename_pkg::*;
#(
    parameter int RENAME_WIDTH = DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
) (
    input  logic        clk,
    input  logic        i_arst_n,
    fifo_port_if.storage port
);

    localparam int PTR_W = $clog2(FREE_DEPTH);
    localparam int CNT_W = $clog2(FREE_DEPTH + 1);

    pr_idx_t          mem [FREE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] wr_ptr [COMMIT_WIDTH];
    logic [PTR_W-1:0] rd_ptr [RENAME_WIDTH];

    int unsigned wr_num;
    int unsigned rd_num;

    // depth need not be a power of two, so wrap explicitly
    // pos never reaches twice the depth, one subtraction is enough
    function automatic logic [PTR_W-1:0] ptr_wrap(input int unsigned pos);
        if (pos >= FREE_DEPTH) begin
            return PTR_W'(pos - FREE_DEPTH);
        end
        return PTR_W'(pos);
    endfunction

    assign wr_num = count_ones(32'(port.wen));
    assign rd_num = count_ones(32'(port.ren));

    // slot addresses for each lane
    always_comb begin
        for (int unsigned k = 0; k < COMMIT_WIDTH; k++) begin
            wr_ptr[k] = ptr_wrap(32'(tail) + k);
        end
        for (int unsigned k = 0; k < RENAME_WIDTH; k++) begin
            rd_ptr[k] = ptr_wrap(32'(head) + k);
        end
    end

    // head window and occupancy, no register between
    always_comb begin
        for (int unsigned k = 0; k < RENAME_WIDTH; k++) begin
            port.rdata[k]    = mem[rd_ptr[k]];
            port.can_read[k] = (32'(count) > k);
        end
    end

    // storage, preloaded with ascending indices on reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int k = 0; k < FREE_DEPTH; k++) begin
                mem[k] <= pr_idx_t'(k + 1);
            end
        end else begin
            for (int unsigned k = 0; k < COMMIT_WIDTH; k++) begin
                if (port.wen[k]) begin
                    mem[wr_ptr[k]] <= port.wdata[k];
                end
            end
        end
    end

    // pointers and count, a write and a read in one cycle both count
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(FREE_DEPTH);
        end else begin
            head  <= ptr_wrap(32'(head) + rd_num);
            tail  <= ptr_wrap(32'(tail) + wr_num);
            count <= CNT_W'(32'(count) + wr_num - rd_num);
        end
    end

endmodule

`default_nettype wire

// ==== freelist.sv ====
`timescale 1ns/1ps
`default_nettype none

// physical register free list of the rename stage
// allocation and return lanes may both be sparse
module freelist
    import rename_pkg::*;
#(
    parameter int RENAME_WIDTH = DEF_RENAME_WIDTH,
    parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
) (
    input  logic                    clk,
    input  logic                    i_arst_n,
    // allocation side
    input  logic [RENAME_WIDTH-1:0] i_alloc_req,
    output logic                    o_can_alloc,
    output pr_idx_t                 o_alloc_pridx [RENAME_WIDTH],
    // return side from commit
    input  logic [COMMIT_WIDTH-1:0] i_dealloc_req,
    input  pr_idx_t                 i_dealloc_pridx [COMMIT_WIDTH]
);

    int unsigned req_num;

    fifo_port_if #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) fifo_port ();

    // returns are packed to the low lanes before reaching the tail
    reorder #(
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_reorder (
        .i_data_vld (i_dealloc_req),
        .i_datas    (i_dealloc_pridx),
        .o_data_vld (fifo_port.wen),
        .o_datas    (fifo_port.wdata)
    );

    multiport_fifo #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .port     (fifo_port.storage)
    );

    // a whole rename group must fit, otherwise nothing is granted
    assign o_can_alloc = &fifo_port.can_read;

    assign req_num = count_ones(32'(i_alloc_req));

    // pop as many entries as there are requests, packed from lane 0
    // e.g. req 1001 pops 0011
    always_comb begin
        for (int unsigned k = 0; k < RENAME_WIDTH; k++) begin
            fifo_port.ren[k] = o_can_alloc && (k < req_num);
        end
    end

    // hand the popped entries to the requesting lanes in order
    redirect #(
        .RENAME_WIDTH (RENAME_WIDTH)
    ) u_redirect (
        .i_req_vld      (i_alloc_req),
        .i_dense_datas  (fifo_port.rdata),
        .o_sparse_datas (o_alloc_pridx)
    );

endmodule

`default_nettype wire

// ==== tb_freelist.sv ====
`timescale 1ns/1ps
`default_nettype none

// self-checking testbench for the rename free list
// a queue models the FIFO contents, held[] tracks indices currently allocated
module tb_freelist
    import rename_pkg::*;
();

    localparam int RW              = DEF_RENAME_WIDTH;
    localparam int CW              = DEF_COMMIT_WIDTH;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int CYCLE_LIMIT     = 2 * STIM_CYCLES;

    logic          clk;
    logic          i_arst_n;
    logic [RW-1:0] alloc_req;
    logic          can_alloc;
    pr_idx_t       alloc_pridx [RW];
    logic [CW-1:0] dealloc_req;
    pr_idx_t       dealloc_pridx [CW];

    // expected free list, head at index 0
    pr_idx_t model [$];
    // indices handed out and not yet returned
    pr_idx_t held [$];
    logic    live [PHYREG_NUM];

    int errors = 0;
    int cycles = 0;

    freelist #(
        .RENAME_WIDTH (RW),
        .COMMIT_WIDTH (CW)
    ) uut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_alloc_req     (alloc_req),
        .o_can_alloc     (can_alloc),
        .o_alloc_pridx   (alloc_pridx),
        .i_dealloc_req   (dealloc_req),
        .i_dealloc_pridx (dealloc_pridx)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: stimulus still running after %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // outputs are stable at the falling edge, inputs change on the rising one
    // the model is advanced here with the inputs the next rising edge samples
    always @(negedge clk) begin : check_outputs
        int      rank;
        pr_idx_t expect_idx;
        logic    grant;
        if (i_arst_n) begin
            grant = (model.size() >= RW);
            assert (can_alloc === grant) else begin
                errors++;
                $display("ERROR o_can_alloc expected %h actual %h", grant, can_alloc);
            end
            rank = 0;
            if (grant) begin
                for (int i = 0; i < RW; i++) begin
                    if (alloc_req[i]) begin
                        expect_idx = model[rank];
                        assert (alloc_pridx[i] === expect_idx) else begin
                            errors++;
                            $display("ERROR o_alloc_pridx[%0d] expected %h actual %h",
                                     i, expect_idx, alloc_pridx[i]);
                        end
                        assert (!live[alloc_pridx[i]]) else begin
                            errors++;
                            $display("index %0d was handed out again while still allocated",
                                     alloc_pridx[i]);
                        end
                        live[expect_idx] = 1'b1;
                        held.push_back(expect_idx);
                        rank++;
                    end
                end
            end
            for (int k = 0; k < rank; k++) begin
                void'(model.pop_front());
            end
            // returns go behind everything stored, in lane order
            for (int i = 0; i < CW; i++) begin
                if (dealloc_req[i]) begin
                    model.push_back(dealloc_pridx[i]);
                    live[dealloc_pridx[i]] = 1'b0;
                end
            end
        end
    end

    // one clock of stimulus; returned indices come from held[]
    // lanes without a return carry junk the DUT has to ignore
    task automatic drive_cycle(input logic [RW-1:0] req, input logic [CW-1:0] ret,
                               input bit pick_random);
        logic [CW-1:0] ret_mask;
        pr_idx_t       ret_idx [CW];
        int unsigned   pos;
        @(posedge clk);
        ret_mask = ret;
        for (int i = 0; i < CW; i++) begin
            ret_idx[i] = pr_idx_t'($urandom);
            if (ret_mask[i]) begin
                if (held.size() == 0) begin
                    ret_mask[i] = 1'b0;
                end else if (pick_random) begin
                    pos        = $urandom_range(held.size() - 1, 0);
                    ret_idx[i] = held[pos];
                    held.delete(pos);
                end else begin
                    ret_idx[i] = held.pop_front();
                end
            end
        end
        alloc_req   <= req;
        dealloc_req <= ret_mask;
        for (int i = 0; i < CW; i++) begin
            dealloc_pridx[i] <= ret_idx[i];
        end
    endtask

    initial begin
        void'($urandom(32'hf1c7));
        i_arst_n    <= 1'b0;
        alloc_req   <= '0;
        dealloc_req <= '0;
        for (int i = 0; i < CW; i++) begin
            dealloc_pridx[i] <= '0;
        end
        for (int k = 0; k < PHYREG_NUM; k++) begin
            live[k] = 1'b0;
        end
        for (int k = 1; k < PHYREG_NUM; k++) begin
            model.push_back(pr_idx_t'(k));
        end

        repeat (RESET_CYCLES) @(posedge clk);
        i_arst_n <= 1'b1;

        // full groups straight out of reset
        drive_cycle('1, '0, 1'b0);
        drive_cycle('1, '0, 1'b0);

        // sparse request on lanes 0 and 3
        drive_cycle(RW'(4'b1001), '0, 1'b0);
        drive_cycle('0, '0, 1'b0);

        // drain until a full group no longer fits, then keep asking
        while (model.size() >= RW) begin
            drive_cycle('1, '0, 1'b0);
        end
        drive_cycle('1, '0, 1'b0);
        drive_cycle(RW'(4'b0110), '0, 1'b0);

        // sparse returns on lanes 1 and 3, then 0 and 2, requests still denied
        drive_cycle('1, CW'(4'b1010), 1'b0);
        drive_cycle('1, CW'(4'b0101), 1'b0);

        // oldest stored entry first, returned ones after it
        drive_cycle('1, '0, 1'b0);
        drive_cycle(RW'(4'b0100), '0, 1'b0);
        drive_cycle('0, '1, 1'b0);
        drive_cycle('0, '0, 1'b0);

        // mixed random traffic
        repeat (RANDOM_CYCLES) begin
            drive_cycle(RW'($urandom), CW'($urandom), 1'b1);
        end

        // give everything back, then empty the list again in order
        drive_cycle('0, '0, 1'b0);
        while (held.size() > 0) begin
            drive_cycle('0, '1, 1'b0);
        end
        drive_cycle('0, '0, 1'b0);
        drive_cycle('0, '0, 1'b0);
        while (model.size() >= RW) begin
            drive_cycle('1, '0, 1'b0);
        end
        drive_cycle('0, '0, 1'b0);
        repeat (2) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== freelist.f ====
rename_pkg.sv
fifo_port_if.sv
reorder.sv
redirect.sv
multiport_fifo.sv
freelist.sv
tb_freelist.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the free list testbench with Verilator and runs it
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f freelist.f --top-module tb_freelist \
    -o sim_freelist > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_freelist > sim.log 2>&1 \
    || { cat sim.log; echo "simulator exited with an error"; exit 1; }

cat sim.log

grep -q "Simulation failed" sim.log && { echo "testbench reported errors"; exit 1; }
exit 0
